/* project.f */
verilog/isaPkg.sv
verilog/decodePkg.sv
verilog/decodeIf.sv
verilog/decodeLoad.sv
verilog/decodeMemAccess.sv
verilog/decodeRegister.sv
verilog/decodeOutReg.sv
verilog/decodeStage.sv
tests/decodeStageTb.sv

/* Makefile */
SRCS := $(shell cat project.f)

.PHONY: all run clean

all: run

obj_dir/VdecodeStageTb: project.f $(SRCS)
	verilator --binary --assert --timing --top-module decodeStageTb -f project.f

run: obj_dir/VdecodeStageTb
	@out="$$(./obj_dir/VdecodeStageTb)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^RESULT: PASS$$"

clean:
	rm -rf obj_dir

/* tests/decodeStageTb.sv */
// Testbench for the memory-class decode stage
// Drives random instructions, flushes and gaps into the DUT and checks the
// registered bundle against a reference decode model one cycle later

`timescale 1ns/10ps

module decodeStageTb;
	import isaPkg::*;
	import decodePkg::*;

	localparam int SEED = 10617;
	localparam int NUM_CYCLES = 2000;
	localparam int RESET_TIMEOUT = 20;

	// Displacement-form opcodes plus the two ALU immediates
	localparam logic [6:0] PLAIN_OPS [13] = '{OP_LDB, OP_LDBU, OP_LDW, OP_LDWU, OP_LDT,
		OP_LDTU, OP_LDO, OP_STB, OP_STW, OP_STT, OP_STO, OP_ADDI, OP_ORI};
	localparam logic [6:0] LDX_FUNCS [8] = '{FN_LDBX, FN_LDBUX, FN_LDWX, FN_LDWUX, FN_LDTX,
		FN_LDTUX, FN_LDOX, FN_LDAX};
	localparam logic [6:0] STX_FUNCS [4] = '{FN_STBX, FN_STWX, FN_STTX, FN_STOX};

	// What the output register should hold after a capture
	typedef struct packed {
		logic load;
		logic store;
		logic [SIZE_W-1:0] size;
		logic sgn;
		logic indexed;
		logic illegal;
		logic writesRt;
		logic [REG_W-1:0] ra;
		logic [REG_W-1:0] rb;
		logic [REG_W-1:0] rt;
		logic [IMM_W-1:0] imm;
	} decodedBundle_t;

	logic clk = 1'b0;
	logic arstN;
	logic inValid;
	logic flush;
	logic [INSTR_W-1:0] instr;
	logic outValid;
	logic outLoad;
	logic outStore;
	logic [SIZE_W-1:0] outSize;
	logic outSigned;
	logic outIndexed;
	logic outIllegal;
	logic [REG_W-1:0] outRa;
	logic [REG_W-1:0] outRb;
	logic [REG_W-1:0] outRt;
	logic outWritesRt;
	logic [IMM_W-1:0] outImm;

	// Model state, mirrors the DUT output register
	logic expValid = 1'b0;
	decodedBundle_t expB = '0;
	logic dataKnown = 1'b0;

	// Stimulus that the DUT will capture at the next rising edge
	logic drvValid = 1'b0;
	logic drvFlush = 1'b0;
	logic [INSTR_W-1:0] drvInstr = '0;

	int checks = 0;
	int errors = 0;
	int ldaxSeen = 0;
	int illegalSeen = 0;
	int flushSeen = 0;
	int rtZeroSeen = 0;

	decodeStage dut (
		.clk(clk),
		.arstN(arstN),
		.inValid(inValid),
		.flush(flush),
		.instr(instr),
		.outValid(outValid),
		.outLoad(outLoad),
		.outStore(outStore),
		.outSize(outSize),
		.outSigned(outSigned),
		.outIndexed(outIndexed),
		.outIllegal(outIllegal),
		.outRa(outRa),
		.outRb(outRb),
		.outRt(outRt),
		.outWritesRt(outWritesRt),
		.outImm(outImm)
	);

	always #5 clk = ~clk;

	initial
	begin
		arstN = 1'b0;
		repeat (8) @(posedge clk);
		arstN <= 1'b1;
	end

	// ====================
	// Reference model
	// ====================

	// Classifies the word first, then derives every flag from the class
	function automatic decodedBundle_t decodeModel(input logic [INSTR_W-1:0] w);
		decodedBundle_t e;
		logic [6:0] opc;
		logic [6:0] fn;
		logic isLoad;
		logic isStore;
		logic isLdax;
		logic isAlu;
		logic idx;
		logic unsignedForm;
		logic legal;
		logic [SIZE_W-1:0] size;
		e = '0;
		opc = w[6:0];
		fn = w[31:25];
		isLoad = 1'b0;
		isStore = 1'b0;
		isLdax = 1'b0;
		isAlu = 1'b0;
		idx = 1'b0;
		size = SZ_BYTE;
		case (opc)
		OP_LDB, OP_LDBU: begin isLoad = 1'b1; size = SZ_BYTE; end
		OP_LDW, OP_LDWU: begin isLoad = 1'b1; size = SZ_WYDE; end
		OP_LDT, OP_LDTU: begin isLoad = 1'b1; size = SZ_TETRA; end
		OP_LDO: begin isLoad = 1'b1; size = SZ_OCTA; end
		OP_STB: begin isStore = 1'b1; size = SZ_BYTE; end
		OP_STW: begin isStore = 1'b1; size = SZ_WYDE; end
		OP_STT: begin isStore = 1'b1; size = SZ_TETRA; end
		OP_STO: begin isStore = 1'b1; size = SZ_OCTA; end
		OP_ADDI, OP_ORI: isAlu = 1'b1;
		OP_LDX:
			begin
				idx = 1'b1;
				case (fn)
				FN_LDBX, FN_LDBUX: begin isLoad = 1'b1; size = SZ_BYTE; end
				FN_LDWX, FN_LDWUX: begin isLoad = 1'b1; size = SZ_WYDE; end
				FN_LDTX, FN_LDTUX: begin isLoad = 1'b1; size = SZ_TETRA; end
				FN_LDOX: begin isLoad = 1'b1; size = SZ_OCTA; end
				FN_LDAX: isLdax = 1'b1;
				default: ;
				endcase
			end
		OP_STX:
			begin
				idx = 1'b1;
				case (fn)
				FN_STBX: begin isStore = 1'b1; size = SZ_BYTE; end
				FN_STWX: begin isStore = 1'b1; size = SZ_WYDE; end
				FN_STTX: begin isStore = 1'b1; size = SZ_TETRA; end
				FN_STOX: begin isStore = 1'b1; size = SZ_OCTA; end
				default: ;
				endcase
			end
		default: ;
		endcase
		// Only the U forms drop sign extension, octa counts as signed
		unsignedForm = (opc inside {OP_LDBU, OP_LDWU, OP_LDTU})
			|| (opc == OP_LDX && (fn inside {FN_LDBUX, FN_LDWUX, FN_LDTUX}));
		legal = isLoad | isStore | isLdax | isAlu;
		e.load = isLoad;
		e.store = isStore;
		e.size = legal ? size : SZ_BYTE;
		e.sgn = isLoad && !unsignedForm;
		e.indexed = legal && idx;
		e.illegal = !legal;
		e.writesRt = legal && !isStore && (w[12:7] != ZERO_REG);
		e.ra = w[18:13];
		e.rt = w[12:7];
		e.imm = w[31:19];
		e.rb = e.indexed ? w[24:19] : ZERO_REG;
		return e;
	endfunction

	// Mixes table picks, indexed forms, raw words and rt-zero variants
	function automatic logic [INSTR_W-1:0] randomInstr();
		logic [INSTR_W-1:0] w;
		logic [3:0] opIdx;
		logic [2:0] ldIdx;
		logic [1:0] stIdx;
		w = $urandom;
		opIdx = 4'($urandom_range(0, 12));
		ldIdx = 3'($urandom_range(0, 7));
		stIdx = 2'($urandom_range(0, 3));
		case ($urandom_range(0, 9))
		0, 1, 2, 3: w[6:0] = PLAIN_OPS[opIdx];
		4, 5: begin w[6:0] = OP_LDX; w[31:25] = LDX_FUNCS[ldIdx]; end
		6: begin w[6:0] = OP_STX; w[31:25] = STX_FUNCS[stIdx]; end
		7: w[6:0] = w[7] ? OP_LDX : OP_STX;
		8: ;
		default:
			begin
				w[6:0] = (opIdx[0]) ? OP_LDX : PLAIN_OPS[opIdx];
				w[31:25] = LDX_FUNCS[ldIdx];
				w[12:7] = 6'd0;
			end
		endcase
		return w;
	endfunction

	// ====================
	// Checking
	// ====================

	task automatic compareField(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		assert (got === exp)
		else
		begin
			errors++;
			$display("[ERROR] %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
		end
	endtask

	// Data fields have no reset, so they count only after the first capture
	task automatic checkOutputs();
		compareField("outValid", 32'(outValid), 32'(expValid));
		compareField("outLoad", 32'(outLoad), 32'(expB.load));
		compareField("outStore", 32'(outStore), 32'(expB.store));
		compareField("outSize", 32'(outSize), 32'(expB.size));
		compareField("outSigned", 32'(outSigned), 32'(expB.sgn));
		compareField("outIndexed", 32'(outIndexed), 32'(expB.indexed));
		compareField("outIllegal", 32'(outIllegal), 32'(expB.illegal));
		compareField("outWritesRt", 32'(outWritesRt), 32'(expB.writesRt));
		if (dataKnown)
		begin
			compareField("outRa", 32'(outRa), 32'(expB.ra));
			compareField("outRb", 32'(outRb), 32'(expB.rb));
			compareField("outRt", 32'(outRt), 32'(expB.rt));
			compareField("outImm", 32'(outImm), 32'(expB.imm));
		end
	endtask

	// Updates the model with what the DUT captured on this edge
	task automatic captureModel();
		expValid = drvValid && !drvFlush;
		if (drvValid)
		begin
			expB = decodeModel(drvInstr);
			dataKnown = 1'b1;
			if (drvInstr[6:0] == OP_LDX && drvInstr[31:25] == FN_LDAX)
				ldaxSeen++;
			if (expB.illegal)
				illegalSeen++;
			if (drvFlush)
				flushSeen++;
			if (drvInstr[12:7] == ZERO_REG)
				rtZeroSeen++;
		end
	endtask

	// ====================
	// Main sequence
	// ====================

	initial
	begin
		int resetWait;
		inValid = 1'b0;
		flush = 1'b0;
		instr = '0;
		void'($urandom(SEED));
		resetWait = 0;
		// Outputs must stay idle while reset is held and right after release
		do
		begin
			@(negedge clk);
			checkOutputs();
			resetWait++;
		end
		while (arstN !== 1'b1 && resetWait < RESET_TIMEOUT);

		if (arstN !== 1'b1)
		begin
			errors++;
			$display("Timed out waiting for reset release");
		end
		else
		begin
			for (int i = 0; i < NUM_CYCLES; i++)
			begin
				@(posedge clk);
				captureModel();
				// A few idle cycles first, then mostly back-to-back traffic
				drvValid = (i >= 3) && ($urandom_range(0, 3) != 0);
				drvFlush = ($urandom_range(0, 7) == 0);
				drvInstr = randomInstr();
				inValid <= drvValid;
				flush <= drvFlush;
				instr <= drvInstr;
				@(negedge clk);
				checkOutputs();
			end

			assert (ldaxSeen > 0 && illegalSeen > 0 && flushSeen > 0 && rtZeroSeen > 0)
			else
			begin
				errors++;
				$display("Stimulus missed a required case: ldax, illegal, flush or rt zero");
			end
		end

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

/* verilog/decodeStage.sv */
// Memory-class decode stage
// Three combinational decoders feed one pipeline register, results
// appear one cycle after the instruction is accepted

`timescale 1ns/10ps

module decodeStage (
	input logic clk,
	input logic arstN,
	input logic inValid,
	input logic flush,
	input logic [isaPkg::INSTR_W-1:0] instr,
	output logic outValid,
	output logic outLoad,
	output logic outStore,
	output logic [decodePkg::SIZE_W-1:0] outSize,
	output logic outSigned,
	output logic outIndexed,
	output logic outIllegal,
	output logic [decodePkg::REG_W-1:0] outRa,
	output logic [decodePkg::REG_W-1:0] outRb,
	output logic [decodePkg::REG_W-1:0] outRt,
	output logic outWritesRt,
	output logic [isaPkg::IMM_W-1:0] outImm
);

	// Instruction word seen through both encoding views
	isaPkg::instruction_t instrWord;

	assign instrWord = instr;

	// Combinational decode results
	decodeIf dec ();

	// ====================
	// Decoders
	// ====================

	decodeLoad uLoad (
		.instr(instrWord),
		.dec(dec.loadSrc)
	);

	decodeMemAccess uMemAccess (
		.instr(instrWord),
		.dec(dec.accessSrc)
	);

	decodeRegister uRegister (
		.instr(instrWord),
		.dec(dec.regSrc)
	);

	// Single pipeline register
	decodeOutReg uOutReg (
		.clk(clk),
		.arstN(arstN),
		.inValid(inValid),
		.flush(flush),
		.instr(instrWord),
		.dec(dec.sink),
		.outValid(outValid),
		.outLoad(outLoad),
		.outStore(outStore),
		.outSize(outSize),
		.outSigned(outSigned),
		.outIndexed(outIndexed),
		.outIllegal(outIllegal),
		.outWritesRt(outWritesRt),
		.outRa(outRa),
		.outRb(outRb),
		.outRt(outRt),
		.outImm(outImm)
	);

endmodule

/* verilog/decodeOutReg.sv */
// Decode output register
// Captures the decoded bundle on valid, one cycle of latency, and drops
// the valid bit on flush

`timescale 1ns/10ps

module decodeOutReg (
	input logic clk,
	input logic arstN,
	input logic inValid,
	input logic flush,
	input isaPkg::instruction_t instr,
	decodeIf.sink dec,
	output logic outValid,
	output logic outLoad,
	output logic outStore,
	output logic [decodePkg::SIZE_W-1:0] outSize,
	output logic outSigned,
	output logic outIndexed,
	output logic outIllegal,
	output logic outWritesRt,
	output logic [decodePkg::REG_W-1:0] outRa,
	output logic [decodePkg::REG_W-1:0] outRb,
	output logic [decodePkg::REG_W-1:0] outRt,
	output logic [isaPkg::IMM_W-1:0] outImm
);

	// ====================
	// Control state
	// ====================

	// Valid follows inValid every cycle, so a gap or a flush empties the slot
	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
			outValid <= 1'b0;
		else
			outValid <= inValid & ~flush;
	end

	// Flags hold their last value while no instruction arrives
	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			outLoad <= 1'b0;
			outStore <= 1'b0;
			outSize <= '0;
			outSigned <= 1'b0;
			outIndexed <= 1'b0;
			outIllegal <= 1'b0;
			outWritesRt <= 1'b0;
		end
		else if (inValid)
		begin
			outLoad <= dec.load;
			outStore <= dec.store;
			outSize <= dec.memSize;
			outSigned <= dec.signedLd;
			outIndexed <= dec.indexed;
			outIllegal <= dec.illegal;
			outWritesRt <= dec.writesRt;
		end
	end

	// ====================
	// Payload
	// ====================

	// Raw fields straight from the word, rb already filtered by the decoder
	always_ff @(posedge clk)
	begin
		if (inValid)
		begin
			outRa <= instr.any.ra;
			outRb <= dec.rb;
			outRt <= instr.any.rt;
			outImm <= instr.any.imm;
		end
	end

	// ====================
	// Checks
	// ====================

	// Load and store come from different decoders and must agree
	assert property (@(posedge clk) disable iff (!arstN)
		outValid |-> !(outLoad && outStore))
		else $error("decodeOutReg: load and store both set");

	// An illegal word reaching the outputs carries no memory or write flag
	assert property (@(posedge clk) disable iff (!arstN)
		outIllegal |-> !(outLoad || outStore || outIndexed || outSigned || outWritesRt))
		else $error("decodeOutReg: illegal instruction with flags set");

	// Address loads are indexed but the classifier must not see a memory read
	assert property (@(posedge clk) disable iff (!arstN)
		(inValid && dec.ldax) |-> (!dec.load && dec.indexed))
		else $error("decodeOutReg: ldax decoded as memory load");

endmodule

/* verilog/decodeRegister.sv */
// Register decoder
// Picks the second source from the indexed form and decides whether the
// target register gets written

`timescale 1ns/10ps

module decodeRegister (
	input isaPkg::instruction_t instr,
	decodeIf.regSrc dec
);
	import decodePkg::*;

	// Target field widened to the decoded register width
	logic [REG_W-1:0] rt;

	assign rt = instr.any.rt;

	// ====================
	// Second source
	// ====================

	// Only the indexed view carries rb, in the immediate view those bits
	// are part of the displacement
	assign dec.rb = dec.indexed ? REG_W'(instr.lsn.rb) : ZERO_REG;

	// ====================
	// Target write
	// ====================

	// Stores use rt as data source, illegal words write nothing, and
	// register zero is never written
	assign dec.writesRt = ~dec.store & ~dec.illegal & (rt != ZERO_REG);

	// The rb pick trusts the access decoder to clear indexed on an
	// illegal word, otherwise displacement bits would leak out as rb
	always_comb
	begin
		assert final (!(dec.illegal && dec.indexed))
			else $error("decodeRegister: illegal word marked as indexed");
	end

endmodule

/* verilog/decodeMemAccess.sv */
// Memory access decoder
// Works out store, size, sign, indexing and address-load flags for each
// encoding and marks every encoding it does not know as illegal

`timescale 1ns/10ps

module decodeMemAccess (
	input isaPkg::instruction_t instr,
	decodeIf.accessSrc dec
);
	import isaPkg::*;
	import decodePkg::*;

	// Raw decode before the illegal case wipes the flags
	logic store;
	logic ldax;
	logic [SIZE_W-1:0] size;
	logic sgn;
	logic indexed;
	logic illegal;

	// ====================
	// Encoding table
	// ====================

	always_comb
	begin
		store = 1'b0;
		ldax = 1'b0;
		size = SZ_BYTE;
		sgn = 1'b0;
		indexed = 1'b0;
		illegal = 1'b0;
		case (instr.any.opcode)
		OP_LDB:  begin size = SZ_BYTE;  sgn = 1'b1; end
		OP_LDBU: size = SZ_BYTE;
		OP_LDW:  begin size = SZ_WYDE;  sgn = 1'b1; end
		OP_LDWU: size = SZ_WYDE;
		OP_LDT:  begin size = SZ_TETRA; sgn = 1'b1; end
		OP_LDTU: size = SZ_TETRA;
		// No unsigned octa, a full-width load counts as signed
		OP_LDO:  begin size = SZ_OCTA;  sgn = 1'b1; end
		OP_LDX:
			begin
				indexed = 1'b1;
				case (instr.lsn.func)
				FN_LDBX:  begin size = SZ_BYTE;  sgn = 1'b1; end
				FN_LDBUX: size = SZ_BYTE;
				FN_LDWX:  begin size = SZ_WYDE;  sgn = 1'b1; end
				FN_LDWUX: size = SZ_WYDE;
				FN_LDTX:  begin size = SZ_TETRA; sgn = 1'b1; end
				FN_LDTUX: size = SZ_TETRA;
				FN_LDOX:  begin size = SZ_OCTA;  sgn = 1'b1; end
				// Address load keeps size zero and is still indexed
				FN_LDAX:  ldax = 1'b1;
				default:  illegal = 1'b1;
				endcase
			end
		// Stores never sign extend
		OP_STB: begin store = 1'b1; size = SZ_BYTE;  end
		OP_STW: begin store = 1'b1; size = SZ_WYDE;  end
		OP_STT: begin store = 1'b1; size = SZ_TETRA; end
		OP_STO: begin store = 1'b1; size = SZ_OCTA;  end
		OP_STX:
			begin
				indexed = 1'b1;
				store = 1'b1;
				case (instr.lsn.func)
				FN_STBX: size = SZ_BYTE;
				FN_STWX: size = SZ_WYDE;
				FN_STTX: size = SZ_TETRA;
				FN_STOX: size = SZ_OCTA;
				default: illegal = 1'b1;
				endcase
			end
		// ALU immediates pass through with no memory flags
		OP_ADDI, OP_ORI: ;
		default: illegal = 1'b1;
		endcase
	end

	// ====================
	// Outputs
	// ====================

	// An illegal encoding must not start any memory activity downstream
	assign dec.store = store & ~illegal;
	assign dec.ldax = ldax & ~illegal;
	assign dec.memSize = illegal ? SZ_BYTE : size;
	assign dec.signedLd = sgn & ~illegal;
	assign dec.indexed = indexed & ~illegal;
	assign dec.illegal = illegal;

endmodule

/* verilog/decodeLoad.sv */
// Load classifier
// Says whether an instruction moves memory data into a register

`timescale 1ns/10ps

module decodeLoad (
	input isaPkg::instruction_t instr,
	decodeIf.loadSrc dec
);
	import isaPkg::*;

	always_comb
	begin
		case (instr.any.opcode)
		OP_LDB, OP_LDBU, OP_LDW, OP_LDWU, OP_LDT, OP_LDTU, OP_LDO:
			dec.load = 1'b1;
		// The indexed opcode reads memory only for the real load funcs
		OP_LDX:
			case (instr.lsn.func)
			FN_LDBX, FN_LDBUX, FN_LDWX, FN_LDWUX, FN_LDTX, FN_LDTUX, FN_LDOX:
				dec.load = 1'b1;
			// FN_LDAX only forms an address, anything else is illegal
			default:
				dec.load = 1'b0;
			endcase
		default:
			dec.load = 1'b0;
		endcase
	end

endmodule

/* verilog/decodeIf.sv */
// Decode result bundle
// Collects the combinational outputs of the three decoders and hands them
// to the pipeline register in one piece

`timescale 1ns/10ps

interface decodeIf;
	import decodePkg::*;

	// Flags from the load classifier and the access decoder
	logic load;
	logic store;
	logic ldax;
	logic [SIZE_W-1:0] memSize;
	logic signedLd;
	logic indexed;
	logic illegal;

	// Register-side results
	logic [REG_W-1:0] rb;
	logic writesRt;

	// Load classifier owns only the load flag
	modport loadSrc (output load);

	// Access decoder owns the rest of the memory flags
	modport accessSrc (output store, ldax, memSize, signedLd, indexed, illegal);

	// Register decoder needs the access class to pick rb and gate the write
	modport regSrc (input store, indexed, illegal, output rb, writesRt);

	// Output register sees everything
	modport sink (input load, store, ldax, memSize, signedLd, indexed, illegal, rb, writesRt);

endinterface

/* verilog/decodePkg.sv */
// Decoded-field definitions
// Access-size codes and widths shared by the decoders and the output register

package decodePkg;

	// ====================
	// Access size
	// ====================

	// Width of the size code handed to the memory pipe
	localparam int SIZE_W = 2;

	// Byte, wyde (16), tetra (32) and octa (64) accesses
	localparam logic [SIZE_W-1:0] SZ_BYTE  = 2'd0;
	localparam logic [SIZE_W-1:0] SZ_WYDE  = 2'd1;
	localparam logic [SIZE_W-1:0] SZ_TETRA = 2'd2;
	localparam logic [SIZE_W-1:0] SZ_OCTA  = 2'd3;

	// ====================
	// Registers
	// ====================

	// Register numbers as the later stages see them
	localparam int REG_W = 6;

	// Register zero reads as zero, a write to it is dropped
	localparam logic [REG_W-1:0] ZERO_REG = 6'd0;

endpackage

/* verilog/isaPkg.sv */
// Instruction encoding for the memory-class decode stage
// Holds the opcode and function codes and the two views of one instruction word

package isaPkg;

	// ====================
	// Field widths
	// ====================

	// Whole instruction word
	localparam int INSTR_W = 32;
	// Displacement carried by the immediate format
	localparam int IMM_W = 13;
	// Major opcode, always in the low bits of the word
	localparam int OPC_W = 7;
	// Function code of the indexed load/store format
	localparam int FN_W = 7;
	// Register fields as they sit in the encoding
	localparam int FLD_W = 6;

	// ====================
	// Major opcodes
	// ====================

	// Loads with a displacement, signed and unsigned pairs
	localparam logic [OPC_W-1:0] OP_LDB  = 7'h40;
	localparam logic [OPC_W-1:0] OP_LDBU = 7'h41;
	localparam logic [OPC_W-1:0] OP_LDW  = 7'h42;
	localparam logic [OPC_W-1:0] OP_LDWU = 7'h43;
	localparam logic [OPC_W-1:0] OP_LDT  = 7'h44;
	localparam logic [OPC_W-1:0] OP_LDTU = 7'h45;
	localparam logic [OPC_W-1:0] OP_LDO  = 7'h46;
	// Indexed loads, the access is picked by the func field
	localparam logic [OPC_W-1:0] OP_LDX  = 7'h4F;
	// Stores with a displacement
	localparam logic [OPC_W-1:0] OP_STB  = 7'h50;
	localparam logic [OPC_W-1:0] OP_STW  = 7'h51;
	localparam logic [OPC_W-1:0] OP_STT  = 7'h52;
	localparam logic [OPC_W-1:0] OP_STO  = 7'h53;
	// Indexed stores
	localparam logic [OPC_W-1:0] OP_STX  = 7'h5F;
	// The only ALU forms this stage knows about
	localparam logic [OPC_W-1:0] OP_ADDI = 7'h04;
	localparam logic [OPC_W-1:0] OP_ORI  = 7'h09;

	// ====================
	// Indexed function codes
	// ====================

	// Valid only under OP_LDX
	localparam logic [FN_W-1:0] FN_LDBX  = 7'h00;
	localparam logic [FN_W-1:0] FN_LDBUX = 7'h01;
	localparam logic [FN_W-1:0] FN_LDWX  = 7'h02;
	localparam logic [FN_W-1:0] FN_LDWUX = 7'h03;
	localparam logic [FN_W-1:0] FN_LDTX  = 7'h04;
	localparam logic [FN_W-1:0] FN_LDTUX = 7'h05;
	localparam logic [FN_W-1:0] FN_LDOX  = 7'h06;
	// Address load, computes ra + rb into rt without touching memory
	localparam logic [FN_W-1:0] FN_LDAX  = 7'h0A;
	// Valid only under OP_STX
	localparam logic [FN_W-1:0] FN_STBX  = 7'h10;
	localparam logic [FN_W-1:0] FN_STWX  = 7'h11;
	localparam logic [FN_W-1:0] FN_STTX  = 7'h12;
	localparam logic [FN_W-1:0] FN_STOX  = 7'h13;

	// ====================
	// Instruction views
	// ====================

	// Immediate format, first member lands in the top bits
	typedef struct packed {
		logic [IMM_W-1:0] imm;
		logic [FLD_W-1:0] ra;
		logic [FLD_W-1:0] rt;
		logic [OPC_W-1:0] opcode;
	} anyInst_t;

	// Indexed load/store format, rb and func replace the displacement
	typedef struct packed {
		logic [FN_W-1:0] func;
		logic [FLD_W-1:0] rb;
		logic [FLD_W-1:0] ra;
		logic [FLD_W-1:0] rt;
		logic [OPC_W-1:0] opcode;
	} lsnInst_t;

	typedef union packed {
		anyInst_t any;
		lsnInst_t lsn;
	} instruction_t;

endpackage
